/* cache_lu.f */
design/cache_pkg.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_lu_pipe.sv
design/cache_fm_req_fifo.sv
design/cache_top.sv
dv/cache_tb.sv

/* design/cache_data_array.sv */
/* data array
   line storage per set and way, full-line write,
   single-word merge write and registered line read */
`default_nettype none

module cache_data_array (
  input  wire                                 clk,
  input  var cache_pkg::t_cl_req              cl_req,
  input  wire [cache_pkg::OFFSET_WIDTH-1:0]   word_offset,
  input  wire [cache_pkg::WORD_WIDTH-1:0]     word_data,
  input  wire                                 word_wr,
  output cache_pkg::t_cl_data                 cl_rd_data
);
  import cache_pkg::*;

  t_cl_data mem [NUM_SETS*NUM_WAYS];
  t_cl_data line_q2;
  t_cl_data merged_q2;

  // current line and the line with one word replaced
  always_comb begin
    line_q2                = mem[cl_req.address];
    merged_q2              = line_q2;
    merged_q2[word_offset] = word_data;
  end

  // fill writes the whole line, write hit writes the merged line
  always_ff @(posedge clk) begin
    if (cl_req.wr_en) begin
      mem[cl_req.address] <= cl_req.cl_data;
    end else if (word_wr) begin
      mem[cl_req.address] <= merged_q2;
    end
  end

  // read data in q3 shows the line after any word write
  always_ff @(posedge clk) begin
    if (cl_req.rd_en) begin
      cl_rd_data <= word_wr ? merged_q2 : line_q2;
    end
  end

endmodule

`default_nettype wire

/* design/cache_fm_req_fifo.sv */
/* fill-request fifo toward far memory
   circular buffer with pointers and count, head shown on fm_req */
`default_nettype none

module cache_fm_req_fifo (
  input  wire                       clk,
  input  wire                       rst_n,
  input  var cache_pkg::t_fm_req    fm_req_in,
  output cache_pkg::t_fm_req        fm_req,
  input  wire                       fm_req_pop,
  output logic                      fm_fifo_full,
  output logic                      fm_fifo_afull
);
  import cache_pkg::*;

  t_fm_req                 mem [FM_FIFO_DEPTH];
  logic [FM_PTR_WIDTH-1:0] wr_ptr, rd_ptr;
  logic [FM_CNT_WIDTH-1:0] count;
  logic                    push, pop;

  assign fm_fifo_full  = (count == FM_CNT_WIDTH'(FM_FIFO_DEPTH));
  // room kept for the two lookups still in flight
  assign fm_fifo_afull = (count >= FM_CNT_WIDTH'(FM_FIFO_DEPTH - 2));

  // push while full is dropped
  assign push = fm_req_in.valid && !fm_fifo_full;
  assign pop  = fm_req_pop && (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= fm_req_in;
    end
  end

  // pointers wrap on the power-of-two depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry, valid when not empty
  always_comb begin
    fm_req       = mem[rd_ptr];
    fm_req.valid = (count != '0);
  end

endmodule

`default_nettype wire

/* design/cache_lu_pipe.sv */
/* lookup pipe
   q1 address decode and set read, q2 tag compare, victim pick,
   set state update and data array access, q3 response and fill request */
`default_nettype none

module cache_lu_pipe (
  input  wire                               clk,
  input  wire                               rst_n,
  input  var cache_pkg::t_lu_req            lu_req,
  output cache_pkg::t_early_lu_rsp          lu_early_rsp,
  output cache_pkg::t_lu_rsp                lu_rsp,
  output cache_pkg::t_set_rd_req            set_rd_req,
  input  var cache_pkg::t_set_rd_rsp        set_rd_rsp,
  output cache_pkg::t_set_wr_req            set_wr_req,
  output cache_pkg::t_cl_req                cl_req,
  output logic [cache_pkg::OFFSET_WIDTH-1:0] word_offset,
  output logic [cache_pkg::WORD_WIDTH-1:0]   word_data,
  output logic                              word_wr,
  input  var cache_pkg::t_cl_data           cl_rd_data,
  output cache_pkg::t_fm_req                fm_req_in
);
  import cache_pkg::*;

  t_pipe_bus            bus_q1, bus_q2_ff, bus_q2, bus_q3;
  logic [NUM_WAYS-1:0]  ways_hit_q2;
  logic [WAY_WIDTH-1:0] enc_hit_q2;
  logic [WAY_WIDTH-1:0] free_way_q2, lru_way_q2, enc_victim_q2;
  logic                 any_free_q2;
  logic                 is_fill_q2;

  //==========================================================================
  // q1: decode and set read
  //==========================================================================
  assign set_rd_req.set = lu_req.address[MSB_SET:LSB_SET];

  always_comb begin
    bus_q1           = '0;
    bus_q1.valid     = lu_req.valid;
    bus_q1.lu_op     = lu_req.lu_op;
    bus_q1.lu_tag    = lu_req.address[MSB_TAG:LSB_TAG];
    bus_q1.lu_set    = lu_req.address[MSB_SET:LSB_SET];
    bus_q1.lu_offset = lu_req.address[MSB_OFFSET:LSB_OFFSET];
    bus_q1.tq_id     = lu_req.tq_id;
    bus_q1.reg_id    = lu_req.reg_id;
    bus_q1.data      = lu_req.data;
    bus_q1.cl_data   = lu_req.cl_data;
  end

  // only the valid bit is cleared
  always_ff @(posedge clk) begin
    bus_q2_ff <= bus_q1;
    if (!rst_n) begin
      bus_q2_ff.valid <= 1'b0;
    end
  end

  //==========================================================================
  // q2: compare, victim, set update, data access
  //==========================================================================
  assign is_fill_q2 = (bus_q2_ff.lu_op == FILL_LU);

  // match against valid ways, lowest way wins the encoding
  always_comb begin : tag_compare
    ways_hit_q2 = '0;
    enc_hit_q2  = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (bus_q2_ff.valid && set_rd_rsp.valid[w] &&
          (set_rd_rsp.tags[w] == bus_q2_ff.lu_tag)) begin
        ways_hit_q2[w] = 1'b1;
        enc_hit_q2     = WAY_WIDTH'(w);
      end
    end
  end

  // first invalid way, else first way with mru clear
  always_comb begin : victim_pick
    free_way_q2 = '0;
    lru_way_q2  = '0;
    any_free_q2 = ~&set_rd_rsp.valid;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!set_rd_rsp.valid[w]) begin
        free_way_q2 = WAY_WIDTH'(w);
      end
      if (!set_rd_rsp.mru[w]) begin
        lru_way_q2 = WAY_WIDTH'(w);
      end
    end
    enc_victim_q2 = any_free_q2 ? free_way_q2 : lru_way_q2;
  end

  always_comb begin : bus_q2_build
    logic [NUM_WAYS-1:0] touch;
    bus_q2             = bus_q2_ff;
    bus_q2.ways_hit    = ways_hit_q2;
    bus_q2.enc_hit     = enc_hit_q2;
    bus_q2.ways_victim = is_fill_q2 ? (NUM_WAYS'(1) << enc_victim_q2) : '0;
    bus_q2.enc_victim  = enc_victim_q2;
    // a fill is never reported as hit or miss
    bus_q2.hit         = (|ways_hit_q2) && !is_fill_q2;
    bus_q2.miss        = bus_q2_ff.valid && !(|ways_hit_q2) && !is_fill_q2;
    // way being used by this lookup
    touch              = is_fill_q2 ? bus_q2.ways_victim : bus_q2.ways_hit;
    bus_q2.new_tags    = set_rd_rsp.tags;
    bus_q2.new_valid   = set_rd_rsp.valid | bus_q2.ways_victim;
    bus_q2.new_mru     = set_rd_rsp.mru | touch;
    if (is_fill_q2) begin
      bus_q2.new_tags[enc_victim_q2] = bus_q2_ff.lu_tag;
    end
    // all mru set, keep only the touched way
    if (&bus_q2.new_mru) begin
      bus_q2.new_mru = touch;
    end
  end

  // set state written back at the end of q2
  assign set_wr_req.en    = bus_q2.valid;
  assign set_wr_req.set   = bus_q2.lu_set;
  assign set_wr_req.tags  = bus_q2.new_tags;
  assign set_wr_req.valid = bus_q2.new_valid;
  assign set_wr_req.mru   = bus_q2.new_mru;

  // fill writes the victim line, read and write hits read the hit line
  assign cl_req.rd_en   = bus_q2.hit;
  assign cl_req.wr_en   = bus_q2.valid && is_fill_q2;
  assign cl_req.address = {bus_q2.lu_set, is_fill_q2 ? bus_q2.enc_victim : bus_q2.enc_hit};
  assign cl_req.cl_data = bus_q2.cl_data;

  assign word_wr     = bus_q2.hit && (bus_q2.lu_op == WR_LU);
  assign word_offset = bus_q2.lu_offset;
  assign word_data   = bus_q2.data;

  // one cycle early read miss
  assign lu_early_rsp.rd_miss    = bus_q2.miss && (bus_q2.lu_op == RD_LU);
  assign lu_early_rsp.lu_tq_id   = bus_q2.tq_id;
  assign lu_early_rsp.cl_address = {bus_q2.lu_tag, bus_q2.lu_set};

  always_ff @(posedge clk) begin
    bus_q3 <= bus_q2;
    if (!rst_n) begin
      bus_q3.valid <= 1'b0;
    end
  end

  //==========================================================================
  // q3: response and fill request
  //==========================================================================
  always_comb begin
    lu_rsp.valid   = bus_q3.valid;
    lu_rsp.lu_op   = bus_q3.lu_op;
    lu_rsp.tq_id   = bus_q3.tq_id;
    lu_rsp.reg_id  = bus_q3.reg_id;
    lu_rsp.address = {bus_q3.lu_tag, bus_q3.lu_set, bus_q3.lu_offset};
    if (!bus_q3.valid) begin
      lu_rsp.lu_result = NO_RSP;
    end else if (bus_q3.lu_op == FILL_LU) begin
      lu_rsp.lu_result = FILL;
    end else begin
      lu_rsp.lu_result = bus_q3.hit ? HIT : MISS;
    end
    // line data: fill line, array line on hit, else zero
    if (bus_q3.lu_op == FILL_LU) begin
      lu_rsp.cl_data = bus_q3.cl_data;
    end else if (bus_q3.hit) begin
      lu_rsp.cl_data = cl_rd_data;
    end else begin
      lu_rsp.cl_data = '0;
    end
  end

  // read or write miss asks far memory for the line
  assign fm_req_in.valid   = bus_q3.valid && bus_q3.miss;
  assign fm_req_in.opcode  = FILL_REQ_OP;
  assign fm_req_in.address = {bus_q3.lu_tag, bus_q3.lu_set, bus_q3.lu_offset};
  assign fm_req_in.tq_id   = bus_q3.tq_id;

endmodule

`default_nettype wire

/* design/cache_pkg.sv */
/* cache lookup package
   organisation and field sizes, address field positions,
   lookup and far memory opcodes, result codes and shared structs */
`default_nettype none

package cache_pkg;

  //==========================================================================
  // organisation and sizes
  //==========================================================================
  localparam int NUM_WAYS        = 4;
  localparam int NUM_SETS        = 16;
  localparam int WAY_WIDTH       = 2;
  localparam int SET_WIDTH       = 4;
  localparam int WORD_WIDTH      = 32;
  localparam int NUM_WORDS_IN_CL = 4;
  localparam int OFFSET_WIDTH    = 2;
  localparam int ADDR_WIDTH      = 16;
  localparam int TAG_WIDTH       = 10;
  localparam int TQ_ID_WIDTH     = 4;
  localparam int REG_ID_WIDTH    = 5;
  localparam int FM_FIFO_DEPTH   = 4;

  // address layout is {tag, set, word offset}
  localparam int LSB_OFFSET    = 0;
  localparam int MSB_OFFSET    = LSB_OFFSET + OFFSET_WIDTH - 1;
  localparam int LSB_SET       = MSB_OFFSET + 1;
  localparam int MSB_SET       = LSB_SET + SET_WIDTH - 1;
  localparam int LSB_TAG       = MSB_SET + 1;
  localparam int MSB_TAG       = ADDR_WIDTH - 1;
  // line address and data array index widths
  localparam int CL_ADDR_WIDTH = TAG_WIDTH + SET_WIDTH;
  localparam int DA_ADDR_WIDTH = SET_WIDTH + WAY_WIDTH;
  // fill-request fifo pointer and level widths
  localparam int FM_PTR_WIDTH  = $clog2(FM_FIFO_DEPTH);
  localparam int FM_CNT_WIDTH  = FM_PTR_WIDTH + 1;

  //==========================================================================
  // opcodes and result codes
  //==========================================================================
  typedef enum logic [1:0] {RD_LU, WR_LU, FILL_LU} t_lu_op;
  typedef enum logic [1:0] {NO_RSP, HIT, MISS, FILL} t_lu_result;
  // room left for more far memory operations
  typedef enum logic [1:0] {FILL_REQ_OP = 2'b00} t_fm_op;

  typedef logic [NUM_WORDS_IN_CL-1:0][WORD_WIDTH-1:0] t_cl_data;

  //==========================================================================
  // interface structs
  //==========================================================================
  typedef struct packed {
    logic                    valid;
    t_lu_op                  lu_op;
    logic [ADDR_WIDTH-1:0]   address;
    logic [WORD_WIDTH-1:0]   data;
    t_cl_data                cl_data;
    logic [TQ_ID_WIDTH-1:0]  tq_id;
    logic [REG_ID_WIDTH-1:0] reg_id;
  } t_lu_req;

  typedef struct packed {
    logic                     rd_miss;
    logic [TQ_ID_WIDTH-1:0]   lu_tq_id;
    logic [CL_ADDR_WIDTH-1:0] cl_address;
  } t_early_lu_rsp;

  typedef struct packed {
    logic                    valid;
    t_lu_op                  lu_op;
    t_lu_result              lu_result;
    logic [TQ_ID_WIDTH-1:0]  tq_id;
    logic [REG_ID_WIDTH-1:0] reg_id;
    logic [ADDR_WIDTH-1:0]   address;
    t_cl_data                cl_data;
  } t_lu_rsp;

  typedef struct packed {
    logic                   valid;
    t_fm_op                 opcode;
    logic [ADDR_WIDTH-1:0]  address;
    logic [TQ_ID_WIDTH-1:0] tq_id;
  } t_fm_req;

  typedef struct packed {
    logic [SET_WIDTH-1:0] set;
  } t_set_rd_req;

  typedef struct packed {
    logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags;
    logic [NUM_WAYS-1:0]                valid;
    logic [NUM_WAYS-1:0]                mru;
  } t_set_rd_rsp;

  typedef struct packed {
    logic                               en;
    logic [SET_WIDTH-1:0]               set;
    logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags;
    logic [NUM_WAYS-1:0]                valid;
    logic [NUM_WAYS-1:0]                mru;
  } t_set_wr_req;

  typedef struct packed {
    logic                     rd_en;
    logic                     wr_en;
    logic [DA_ADDR_WIDTH-1:0] address;
    t_cl_data                 cl_data;
  } t_cl_req;

  // record carried down the lookup pipe
  typedef struct packed {
    logic                               valid;
    t_lu_op                             lu_op;
    logic [TAG_WIDTH-1:0]               lu_tag;
    logic [SET_WIDTH-1:0]               lu_set;
    logic [OFFSET_WIDTH-1:0]            lu_offset;
    logic [TQ_ID_WIDTH-1:0]             tq_id;
    logic [REG_ID_WIDTH-1:0]            reg_id;
    logic [WORD_WIDTH-1:0]              data;
    t_cl_data                           cl_data;
    logic [NUM_WAYS-1:0]                ways_hit;
    logic [WAY_WIDTH-1:0]               enc_hit;
    logic [NUM_WAYS-1:0]                ways_victim;
    logic [WAY_WIDTH-1:0]               enc_victim;
    logic                               hit;
    logic                               miss;
    logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] new_tags;
    logic [NUM_WAYS-1:0]                new_valid;
    logic [NUM_WAYS-1:0]                new_mru;
  } t_pipe_bus;

endpackage

`default_nettype wire

/* design/cache_tag_array.sv */
/* tag array
   per-set tags, valid and mru bits, registered q1 read,
   q2 write port with same-set bypass into the read data */
`default_nettype none

module cache_tag_array (
  input  wire                           clk,
  input  wire                           rst_n,
  input  var cache_pkg::t_set_rd_req    set_rd_req,
  output cache_pkg::t_set_rd_rsp        set_rd_rsp,
  input  var cache_pkg::t_set_wr_req    set_wr_req
);
  import cache_pkg::*;

  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags_mem  [NUM_SETS];
  logic [NUM_WAYS-1:0]                valid_mem [NUM_SETS];
  logic [NUM_WAYS-1:0]                mru_mem   [NUM_SETS];
  logic                               bypass;

  // q1 reads the set q2 is updating this cycle
  assign bypass = set_wr_req.en && (set_wr_req.set == set_rd_req.set);

  // tag storage
  always_ff @(posedge clk) begin
    if (set_wr_req.en) begin
      tags_mem[set_wr_req.set] <= set_wr_req.tags;
    end
  end

  // valid and mru state, cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_mem[s] <= '0;
        mru_mem[s]   <= '0;
      end
    end else if (set_wr_req.en) begin
      valid_mem[set_wr_req.set] <= set_wr_req.valid;
      mru_mem[set_wr_req.set]   <= set_wr_req.mru;
    end
  end

  // registered read, lands in q2
  always_ff @(posedge clk) begin
    if (bypass) begin
      set_rd_rsp.tags  <= set_wr_req.tags;
      set_rd_rsp.valid <= set_wr_req.valid;
      set_rd_rsp.mru   <= set_wr_req.mru;
    end else begin
      set_rd_rsp.tags  <= tags_mem[set_rd_req.set];
      set_rd_rsp.valid <= valid_mem[set_rd_req.set];
      set_rd_rsp.mru   <= mru_mem[set_rd_req.set];
    end
  end

endmodule

`default_nettype wire

/* design/cache_top.sv */
/* cache lookup top
   lookup pipe, tag array, data array and fill-request fifo */
`default_nettype none

module cache_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  var cache_pkg::t_lu_req      lu_req,
  output cache_pkg::t_early_lu_rsp    lu_early_rsp,
  output cache_pkg::t_lu_rsp          lu_rsp,
  output cache_pkg::t_fm_req          fm_req,
  input  wire                         fm_req_pop,
  output logic                        fm_fifo_afull
);
  import cache_pkg::*;

  t_set_rd_req             set_rd_req;
  t_set_rd_rsp             set_rd_rsp;
  t_set_wr_req             set_wr_req;
  t_cl_req                 cl_req;
  t_cl_data                cl_rd_data;
  t_fm_req                 fm_req_in;
  logic [OFFSET_WIDTH-1:0] word_offset;
  logic [WORD_WIDTH-1:0]   word_data;
  logic                    word_wr;

  // producer of lookups and fill requests
  cache_lu_pipe u_lu_pipe (
    .clk          (clk),
    .rst_n        (rst_n),
    .lu_req       (lu_req),
    .lu_early_rsp (lu_early_rsp),
    .lu_rsp       (lu_rsp),
    .set_rd_req   (set_rd_req),
    .set_rd_rsp   (set_rd_rsp),
    .set_wr_req   (set_wr_req),
    .cl_req       (cl_req),
    .word_offset  (word_offset),
    .word_data    (word_data),
    .word_wr      (word_wr),
    .cl_rd_data   (cl_rd_data),
    .fm_req_in    (fm_req_in)
  );

  cache_tag_array u_tag_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .set_rd_req (set_rd_req),
    .set_rd_rsp (set_rd_rsp),
    .set_wr_req (set_wr_req)
  );

  cache_data_array u_data_array (
    .clk         (clk),
    .cl_req      (cl_req),
    .word_offset (word_offset),
    .word_data   (word_data),
    .word_wr     (word_wr),
    .cl_rd_data  (cl_rd_data)
  );

  // buffer drained by far memory
  cache_fm_req_fifo u_fm_req_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .fm_req_in     (fm_req_in),
    .fm_req        (fm_req),
    .fm_req_pop    (fm_req_pop),
    .fm_fifo_full  (),
    .fm_fifo_afull (fm_fifo_afull)
  );

endmodule

`default_nettype wire

/* dv/cache_tb.sv */
/* cache lookup testbench
   clock, reset, watchdog, far memory pop model, reference model of the
   tag and data arrays, per-cycle assertions and the directed and random tests */
`default_nettype none

module cache_tb;
  import cache_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_SKEW = 10;
  // cycle budget per test, afull waits and drains included
  localparam int STIM_CYCLES   = 20 + 30 + 40 + 60 + 120 + 250;
  localparam int MARGIN_CYCLES = 500;

  // expected outputs of one lookup
  typedef struct packed {
    t_early_lu_rsp early;
    t_lu_rsp       rsp;
    t_fm_req       fm;
  } t_expect;

  logic          clk;
  logic          rst_n;
  t_lu_req       lu_req;
  t_early_lu_rsp lu_early_rsp;
  t_lu_rsp       lu_rsp;
  t_fm_req       fm_req;
  logic          fm_req_pop;
  logic          fm_fifo_afull;

  // expected values for the request being driven and the two stages behind it
  t_expect exp_in, exp_q2, exp_q3;
  t_fm_req fm_exp [$];

  // reference model of the cache state
  logic [TAG_WIDTH-1:0] m_tags  [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0]  m_valid [NUM_SETS];
  logic [NUM_WAYS-1:0]  m_mru   [NUM_SETS];
  t_cl_data             m_data  [NUM_SETS][NUM_WAYS];

  int                     errors      = 0;
  int                     err_mark    = 0;
  int                     tests_run   = 0;
  int                     tests_bad   = 0;
  int                     pop_percent = 0;
  logic [TQ_ID_WIDTH-1:0] next_tq     = '0;

  cache_top u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .lu_req        (lu_req),
    .lu_early_rsp  (lu_early_rsp),
    .lu_rsp        (lu_rsp),
    .fm_req        (fm_req),
    .fm_req_pop    (fm_req_pop),
    .fm_fifo_afull (fm_fifo_afull)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((STIM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired at %0t before the tests finished", $time);
    $display("Something failed");
    $finish;
  end

  // far memory pops the head at a random rate
  always begin
    @(posedge clk);
    #DRIVE_SKEW;
    fm_req_pop = fm_req.valid && (pop_percent > 0) && ($urandom_range(99) < pop_percent);
  end

  //==========================================================================
  // reference model
  //==========================================================================
  function automatic logic [ADDR_WIDTH-1:0] make_addr(input int tag, input int set,
                                                      input int off);
    return {TAG_WIDTH'(tag), SET_WIDTH'(set), OFFSET_WIDTH'(off)};
  endfunction

  function automatic t_cl_data rand_line();
    t_cl_data line;
    for (int w = 0; w < NUM_WORDS_IN_CL; w++) begin
      line[w] = $urandom;
    end
    return line;
  endfunction

  // tag already present in a valid way of the set
  function automatic bit model_has(input int tag, input int set);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[set][w] && (m_tags[set][w] == TAG_WIDTH'(tag))) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic model_lookup(input t_lu_req req, output t_expect e);
    logic [TAG_WIDTH-1:0]    tag;
    logic [SET_WIDTH-1:0]    set;
    logic [OFFSET_WIDTH-1:0] off;
    logic [NUM_WAYS-1:0]     touch;
    int                      hit_way;
    int                      vic;
    tag     = req.address[ADDR_WIDTH-1 -: TAG_WIDTH];
    set     = req.address[OFFSET_WIDTH +: SET_WIDTH];
    off     = req.address[OFFSET_WIDTH-1:0];
    touch   = '0;
    hit_way = -1;
    vic     = -1;
    // lowest matching way
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (m_valid[set][w] && (m_tags[set][w] == tag)) begin
        hit_way = w;
      end
    end
    e                     = '0;
    e.rsp.valid           = 1'b1;
    e.rsp.lu_op           = req.lu_op;
    e.rsp.tq_id           = req.tq_id;
    e.rsp.reg_id          = req.reg_id;
    e.rsp.address         = req.address;
    e.early.lu_tq_id      = req.tq_id;
    e.early.cl_address    = {tag, set};
    if (req.lu_op == FILL_LU) begin
      // first free way, else first way not recently used
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (!m_valid[set][w] && vic < 0) begin
          vic = w;
        end
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (!m_mru[set][w] && vic < 0) begin
          vic = w;
        end
      end
      if (vic < 0) begin
        vic = 0;
      end
      m_valid[set][vic] = 1'b1;
      m_tags[set][vic]  = tag;
      m_data[set][vic]  = req.cl_data;
      touch[vic]        = 1'b1;
      e.rsp.lu_result   = FILL;
      e.rsp.cl_data     = req.cl_data;
    end else if (hit_way >= 0) begin
      if (req.lu_op == WR_LU) begin
        m_data[set][hit_way][off] = req.data;
      end
      touch[hit_way]  = 1'b1;
      e.rsp.lu_result = HIT;
      // write hit returns the line with the new word
      e.rsp.cl_data   = m_data[set][hit_way];
    end else begin
      e.rsp.lu_result  = MISS;
      e.early.rd_miss  = (req.lu_op == RD_LU);
      e.fm.valid       = 1'b1;
      e.fm.opcode      = FILL_REQ_OP;
      e.fm.address     = req.address;
      e.fm.tq_id       = req.tq_id;
    end
    m_mru[set] = m_mru[set] | touch;
    if (&m_mru[set]) begin
      m_mru[set] = touch;
    end
  endtask

  // expected pipe stages and fill-request queue follow the clock
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q2 <= '0;
      exp_q3 <= '0;
      fm_exp.delete();
    end else begin
      if (fm_req_pop && fm_exp.size() != 0) begin
        void'(fm_exp.pop_front());
      end
      if (exp_q3.fm.valid) begin
        fm_exp.push_back(exp_q3.fm);
      end
      exp_q2 <= exp_in;
      exp_q3 <= exp_q2;
    end
  end

  //==========================================================================
  // checks, sampled at the falling edge
  //==========================================================================
  task automatic check(input string name, input logic [255:0] expected,
                       input logic [255:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED at %0t: %s expected %0h actual %0h",
               $time, name, expected, actual);
      errors++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      check("lu_early_rsp.rd_miss", exp_q2.early.rd_miss, lu_early_rsp.rd_miss);
      if (exp_q2.rsp.valid) begin
        check("lu_early_rsp.lu_tq_id", exp_q2.early.lu_tq_id, lu_early_rsp.lu_tq_id);
        check("lu_early_rsp.cl_address", exp_q2.early.cl_address,
              lu_early_rsp.cl_address);
      end
      check("lu_rsp.valid", exp_q3.rsp.valid, lu_rsp.valid);
      if (exp_q3.rsp.valid) begin
        check("lu_rsp", exp_q3.rsp, lu_rsp);
      end
      check("fm_req.valid", fm_exp.size() != 0, fm_req.valid);
      if (fm_exp.size() != 0) begin
        check("fm_req", fm_exp[0], fm_req);
      end
      check("fm_fifo_afull", fm_exp.size() >= FM_FIFO_DEPTH - 2, fm_fifo_afull);
    end
  end

  //==========================================================================
  // stimulus
  //==========================================================================
  task automatic idle();
    @(posedge clk);
    #DRIVE_SKEW;
    lu_req = '0;
    exp_in = '0;
  endtask

  // reads and writes hold off while the fifo is almost full
  task automatic issue(input t_lu_op op, input logic [ADDR_WIDTH-1:0] addr);
    t_lu_req req;
    t_expect e;
    @(posedge clk);
    #DRIVE_SKEW;
    while (op != FILL_LU && fm_fifo_afull) begin
      lu_req = '0;
      exp_in = '0;
      @(posedge clk);
      #DRIVE_SKEW;
    end
    req         = '0;
    req.valid   = 1'b1;
    req.lu_op   = op;
    req.address = addr;
    req.data    = $urandom;
    req.cl_data = rand_line();
    req.tq_id   = next_tq;
    req.reg_id  = REG_ID_WIDTH'($urandom_range(31));
    next_tq     = next_tq + 1'b1;
    model_lookup(req, e);
    lu_req = req;
    exp_in = e;
  endtask

  // empty the pipe, then let far memory take every queued request
  task automatic drain();
    repeat (3) idle();
    pop_percent = 100;
    while (fm_exp.size() != 0) begin
      idle();
    end
    pop_percent = 0;
    repeat (2) idle();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_bad++;
    end
    $display("test %0d %s: %s, %0d failed checks", tests_run, name,
             (errors == err_mark) ? "pass" : "fail", errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    int tag;
    int set;
    t_lu_op op;
    void'($urandom(59));
    rst_n      = 1'b0;
    lu_req     = '0;
    fm_req_pop = 1'b0;
    exp_in     = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[s] = '0;
      m_mru[s]   = '0;
    end
    repeat (4) @(posedge clk);
    #DRIVE_SKEW;
    rst_n = 1'b1;

    // cold miss sits in the fifo until far memory pops it
    issue(RD_LU, make_addr('h011, 3, 1));
    repeat (4) idle();
    drain();
    end_test("cold read miss");

    pop_percent = 50;
    issue(FILL_LU, make_addr('h022, 4, 0));
    issue(RD_LU, make_addr('h022, 4, 2));
    repeat (3) idle();
    issue(RD_LU, make_addr('h022, 4, 3));
    drain();
    end_test("fill then read");

    pop_percent = 50;
    issue(FILL_LU, make_addr('h033, 6, 0));
    issue(WR_LU, make_addr('h033, 6, 2));
    issue(RD_LU, make_addr('h033, 6, 0));
    issue(WR_LU, make_addr('h034, 6, 1));
    issue(RD_LU, make_addr('h034, 6, 1));
    issue(RD_LU, make_addr('h033, 6, 1));
    drain();
    end_test("write hit and miss");

    // six tags into one four-way set
    pop_percent = 50;
    for (int i = 0; i < 6; i++) begin
      issue(FILL_LU, make_addr('h100 + i, 9, 0));
      issue(RD_LU, make_addr('h100 + $urandom_range(i), 9, $urandom_range(3)));
    end
    for (int i = 0; i < 6; i++) begin
      issue(RD_LU, make_addr('h100 + i, 9, 0));
    end
    drain();
    end_test("replacement");

    pop_percent = 25;
    for (int i = 0; i < 12; i++) begin
      issue(RD_LU, make_addr('h200 + i, 12, i % NUM_WORDS_IN_CL));
    end
    drain();
    end_test("fill request fifo");

    // fills only bring in tags not yet present
    pop_percent = 50;
    for (int n = 0; n < 60; n++) begin
      set = $urandom_range(2);
      tag = 'h300 + $urandom_range(5);
      op  = t_lu_op'($urandom_range(2));
      if (op == FILL_LU && model_has(tag, set)) begin
        op = RD_LU;
      end
      issue(op, make_addr(tag, set, $urandom_range(3)));
    end
    drain();
    end_test("random mix");

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
